//--- design/axis_if.sv
// ----------------------------------------------------------------------
// AXI4-Stream link between router blocks
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface axis_if;

    logic                    tvalid;            // Beat present
    logic                    tready;            // Sink can take it
    stream_route_pkg::data_t tdata;             // Payload
    stream_route_pkg::dest_t tdest;             // Destination code
    logic                    tlast;             // End of packet

    // Upstream side
    modport source (
        output tvalid,
        input  tready,
        output tdata,
        output tdest,
        output tlast
    );

    // Downstream side
    modport sink (
        input  tvalid,
        output tready,
        input  tdata,
        input  tdest,
        input  tlast
    );

endinterface

`default_nettype wire

//--- design/route_stage.sv
// ----------------------------------------------------------------------
// Router chain stage
// Delivers beats of its output group, passes the rest down the chain
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module route_stage #(
    parameter int base = 0                              // First output of this group
) (
    input  logic                                                      aclk,
    input  logic                                                      areset_n,
    axis_if.sink                                                      prev,
    axis_if.source                                                    next,
    output logic [stream_route_pkg::group_size-1:0]                   local_tvalid,
    input  logic [stream_route_pkg::group_size-1:0]                   local_tready,
    output stream_route_pkg::data_t [stream_route_pkg::group_size-1:0] local_tdata,
    output stream_route_pkg::dest_t [stream_route_pkg::group_size-1:0] local_tdest,
    output logic [stream_route_pkg::group_size-1:0]                   local_tlast
);

    localparam int group_size = stream_route_pkg::group_size;
    localparam int sel_width  = $clog2(group_size);     // Local output index bits

    logic                    in_group;                  // Code belongs to this stage
    logic [sel_width-1:0]    sel;                       // Local output for the code
    logic [group_size-1:0]   local_free;                // Register can take a beat
    logic [group_size-1:0]   local_load;
    logic                    accept;                    // Input handshake
    logic                    fwd_free;
    logic                    fwd_load;

    logic                    fwd_valid;                 // Forward register
    stream_route_pkg::data_t fwd_data;
    stream_route_pkg::dest_t fwd_dest;
    logic                    fwd_last;

    // Identity map, output number equals code
    assign in_group = (int'(prev.tdest) >= base) && (int'(prev.tdest) < base + group_size);
    assign sel      = sel_width'(int'(prev.tdest) - base);

    // Empty or draining this cycle
    assign local_free = ~local_tvalid | local_tready;
    assign fwd_free   = !fwd_valid || next.tready;

    // Stall on the register the head beat needs, keeps order
    assign prev.tready = in_group ? local_free[sel] : fwd_free;
    assign accept      = prev.tvalid && prev.tready;
    assign fwd_load    = accept && !in_group;

    for (genvar i = 0; i < group_size; i++) begin : local_g
        assign local_load[i] = accept && in_group && (sel == sel_width'(i));

        // Held beat stays put until its sink takes it
        a_local_stable: assert property (
            @(posedge aclk) disable iff (!areset_n)
            local_tvalid[i] && !local_tready[i] |=>
                local_tvalid[i] && $stable(local_tdata[i]) &&
                $stable(local_tdest[i]) && $stable(local_tlast[i])
        );

        // Only this output's own code ever lands here
        a_local_code: assert property (
            @(posedge aclk) disable iff (!areset_n)
            local_tvalid[i] |-> (local_tdest[i] == stream_route_pkg::dest_t'(base + i))
        );
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            local_tvalid <= '0;
            fwd_valid    <= 1'b0;
        end else begin
            for (int i = 0; i < group_size; i++) begin
                if (local_load[i]) begin
                    local_tvalid[i] <= 1'b1;            // Refill wins over drain
                end else if (local_tready[i]) begin
                    local_tvalid[i] <= 1'b0;
                end
            end
            if (fwd_load) begin
                fwd_valid <= 1'b1;
            end else if (next.tready) begin
                fwd_valid <= 1'b0;
            end
        end
    end

    // Payload registers, loaded on the handshake only
    always_ff @(posedge aclk) begin
        for (int i = 0; i < group_size; i++) begin
            if (local_load[i]) begin
                local_tdata[i] <= prev.tdata;
                local_tdest[i] <= prev.tdest;
                local_tlast[i] <= prev.tlast;
            end
        end
        if (fwd_load) begin
            fwd_data <= prev.tdata;
            fwd_dest <= prev.tdest;
            fwd_last <= prev.tlast;
        end
    end

    assign next.tvalid = fwd_valid;
    assign next.tdata  = fwd_data;
    assign next.tdest  = fwd_dest;
    assign next.tlast  = fwd_last;

    // Forwarded beat holds until the next stage takes it
    a_fwd_stable: assert property (
        @(posedge aclk) disable iff (!areset_n)
        next.tvalid && !next.tready |=>
            next.tvalid && $stable(next.tdata) && $stable(next.tdest) && $stable(next.tlast)
    );

endmodule

`default_nettype wire

//--- design/stream_discard.sv
// ----------------------------------------------------------------------
// Router chain tail
// Drains beats no stage claimed and counts them
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stream_discard (
    input  logic                     aclk,
    input  logic                     areset_n,
    axis_if.sink                     rx,
    output stream_route_pkg::count_t drop_count
);

    logic ready_q;                                      // Rises one cycle after reset
    logic take;                                         // Beat consumed this cycle

    assign rx.tready = ready_q;
    assign take      = rx.tvalid && rx.tready;

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            ready_q    <= 1'b0;
            drop_count <= '0;
        end else begin
            ready_q <= 1'b1;                            // Always drains afterwards
            if (take && (drop_count != '1)) begin
                drop_count <= drop_count + stream_route_pkg::count_t'(1);  // Saturates
            end
        end
    end

    // Upstream stages must have claimed every code below outputs
    a_unmatched_only: assert property (
        @(posedge aclk) disable iff (!areset_n)
        take |-> (int'(rx.tdest) >= stream_route_pkg::outputs) &&
                 !$isunknown({rx.tdata, rx.tlast})
    );

endmodule

`default_nettype wire

//--- design/stream_ingress.sv
// ----------------------------------------------------------------------
// Router ingress slice
// Two-entry skid buffer so rx_tready comes from a flop, not the chain
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stream_ingress (
    input  logic                    aclk,
    input  logic                    areset_n,
    input  logic                    rx_tvalid,
    output logic                    rx_tready,
    input  stream_route_pkg::data_t rx_tdata,
    input  stream_route_pkg::dest_t rx_tdest,
    input  logic                    rx_tlast,
    axis_if.source                  tx
);

    stream_route_pkg::ingress_state_t state;            // Current occupancy
    stream_route_pkg::ingress_state_t state_next;       // Occupancy after this edge

    stream_route_pkg::data_t buf_data [2];              // Entry payloads
    stream_route_pkg::dest_t buf_dest [2];
    logic                    buf_last [2];

    logic wr_ptr;                                       // Next entry to fill
    logic rd_ptr;                                       // Entry shown on tx
    logic push;
    logic pop;

    assign push = rx_tvalid && rx_tready;               // Beat taken from rx
    assign pop  = tx.tvalid && tx.tready;               // Beat handed to chain

    always_comb begin
        state_next = state;
        case (state)
            stream_route_pkg::empty: begin
                if (push) begin
                    state_next = stream_route_pkg::one;
                end
            end
            stream_route_pkg::one: begin
                if (push && !pop) begin
                    state_next = stream_route_pkg::two;
                end else if (pop && !push) begin
                    state_next = stream_route_pkg::empty;
                end
            end
            stream_route_pkg::two: begin
                if (pop) begin
                    state_next = stream_route_pkg::one;   // rx blocked while full
                end
            end
            default: state_next = stream_route_pkg::empty;
        endcase
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state     <= stream_route_pkg::empty;
            wr_ptr    <= 1'b0;
            rd_ptr    <= 1'b0;
            rx_tready <= 1'b0;                          // Held low through reset
        end else begin
            state     <= state_next;
            rx_tready <= (state_next != stream_route_pkg::two);  // Room for one more
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            buf_data[wr_ptr] <= rx_tdata;
            buf_dest[wr_ptr] <= rx_tdest;
            buf_last[wr_ptr] <= rx_tlast;
        end
    end

    assign tx.tvalid = (state != stream_route_pkg::empty);
    assign tx.tdata  = buf_data[rd_ptr];                // Oldest entry first
    assign tx.tdest  = buf_dest[rd_ptr];
    assign tx.tlast  = buf_last[rd_ptr];

    // Registered ready must already be low once both entries hold beats
    a_no_push_when_full: assert property (
        @(posedge aclk) disable iff (!areset_n)
        (state == stream_route_pkg::two) |-> !push
    );

endmodule

`default_nettype wire

//--- design/stream_route_pkg.sv
// ----------------------------------------------------------------------
// Stream router package
// Widths, counts and shared types of the AXI4-Stream router
// ----------------------------------------------------------------------
`default_nettype none

package stream_route_pkg;

    // Beat format
    localparam int data_width  = 32;            // Payload bits per beat
    localparam int dest_width  = 4;             // Destination code bits

    // Output layout, identity map from code to output
    localparam int outputs     = 8;             // Routed outputs
    localparam int group_size  = 4;             // Outputs served by one stage
    localparam int stages      = (outputs + group_size - 1) / group_size;

    // Tail counter
    localparam int count_width = 16;            // Drop counter bits

    typedef logic [data_width-1:0]  data_t;     // Beat payload
    typedef logic [dest_width-1:0]  dest_t;     // Destination code
    typedef logic [count_width-1:0] count_t;    // Dropped beat count

    // Ingress skid register occupancy
    typedef enum logic [1:0] {
        empty = 2'd0,                           // No beat held
        one   = 2'd1,                           // One beat held
        two   = 2'd2                            // Both entries full
    } ingress_state_t;

endpackage

`default_nettype wire

//--- design/stream_route_top.sv
// ----------------------------------------------------------------------
// AXI4-Stream router top
// One rx stream to eight outputs by tdest through a chain of stages
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stream_route_top (
    input  logic                                                     aclk,
    input  logic                                                     areset_n,
    input  logic                                                     rx_tvalid,
    output logic                                                     rx_tready,
    input  stream_route_pkg::data_t                                  rx_tdata,
    input  stream_route_pkg::dest_t                                  rx_tdest,
    input  logic                                                     rx_tlast,
    output logic [stream_route_pkg::outputs-1:0]                     tx_tvalid,
    input  logic [stream_route_pkg::outputs-1:0]                     tx_tready,
    output stream_route_pkg::data_t [stream_route_pkg::outputs-1:0]  tx_tdata,
    output stream_route_pkg::dest_t [stream_route_pkg::outputs-1:0]  tx_tdest,
    output logic [stream_route_pkg::outputs-1:0]                     tx_tlast,
    output stream_route_pkg::count_t                                 drop_count
);

    // Chain links, 0 from ingress, last one into the discard tail
    axis_if chain [0:stream_route_pkg::stages] ();

    // Registered entry point, decouples rx_tready from the chain
    stream_ingress ingress_i (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready),
        .rx_tdata  (rx_tdata),
        .rx_tdest  (rx_tdest),
        .rx_tlast  (rx_tlast),
        .tx        (chain[0])
    );

    // One stage per group of outputs, each adds a cycle for later groups
    for (genvar g = 0; g < stream_route_pkg::stages; g++) begin : stage_g
        localparam int lo = g * stream_route_pkg::group_size;  // First output served

        route_stage #(
            .base (lo)
        ) stage_i (
            .aclk         (aclk),
            .areset_n     (areset_n),
            .prev         (chain[g]),
            .next         (chain[g+1]),
            .local_tvalid (tx_tvalid[lo +: stream_route_pkg::group_size]),
            .local_tready (tx_tready[lo +: stream_route_pkg::group_size]),
            .local_tdata  (tx_tdata[lo +: stream_route_pkg::group_size]),
            .local_tdest  (tx_tdest[lo +: stream_route_pkg::group_size]),
            .local_tlast  (tx_tlast[lo +: stream_route_pkg::group_size])
        );
    end

    // Codes 8 to 15 end up here
    stream_discard discard_i (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .rx         (chain[stream_route_pkg::stages]),
        .drop_count (drop_count)
    );

endmodule

`default_nettype wire

//--- files.f
design/stream_route_pkg.sv
design/axis_if.sv
design/stream_ingress.sv
design/route_stage.sv
design/stream_discard.sv
design/stream_route_top.sv
verification/clock_gen.sv
verification/stream_route_tb.sv

//--- verification/clock_gen.sv
// ----------------------------------------------------------------------
// Testbench clock and reset source
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int half_period  = 20,                    // 40 ns clock period
    parameter int reset_cycles = 8                      // Edges held in reset
) (
    output logic aclk,
    output logic areset_n
);

    initial begin
        aclk = 1'b0;
        forever #(half_period) aclk = ~aclk;
    end

    initial begin
        areset_n = 1'b0;
        repeat (reset_cycles) @(posedge aclk);
        #1 areset_n = 1'b1;                             // Release just after an edge
    end

endmodule

`default_nettype wire

//--- verification/stream_route_tb.sv
// ----------------------------------------------------------------------
// Stream router testbench
// Table-driven beats, per-output scoreboards, random back-pressure
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stream_route_tb;

    localparam int outputs      = stream_route_pkg::outputs;
    localparam int reset_cycles = 8;
    localparam int drive_delay  = 2;                    // ns after the rising edge
    localparam int num_beats    = 40;                   // Table length
    localparam int timeout_cycles = (num_beats + outputs) * 20 + reset_cycles;

    // Table row and scoreboard entry
    typedef struct packed {
        stream_route_pkg::dest_t dest;
        stream_route_pkg::data_t data;
        logic                    last;
        logic                    rand_rdy;              // Random tx_tready while sent
    } entry_t;

    logic aclk;
    logic areset_n;

    logic                                          rx_tvalid;
    logic                                          rx_tready;
    stream_route_pkg::data_t                       rx_tdata;
    stream_route_pkg::dest_t                       rx_tdest;
    logic                                          rx_tlast;
    logic [outputs-1:0]                            tx_tvalid;
    logic [outputs-1:0]                            tx_tready;
    stream_route_pkg::data_t [outputs-1:0]         tx_tdata;
    stream_route_pkg::dest_t [outputs-1:0]         tx_tdest;
    logic [outputs-1:0]                            tx_tlast;
    stream_route_pkg::count_t                      drop_count;

    entry_t stim [num_beats];                           // Stimulus table
    entry_t exp_q [outputs][$];                         // Expected beats per output
    int     exp_drops;                                  // Expected unmatched beats
    logic   rand_ready;                                 // Back-pressure mode in force
    int     cycle;                                      // Rising edge counter
    int     last_hs;                                    // Edge of the latest rx handshake
    int     lat_out;                                    // Output under latency watch
    int     lat_hs;
    logic   lat_armed;

    clock_gen #(
        .reset_cycles (reset_cycles)
    ) clock_gen_i (
        .aclk     (aclk),
        .areset_n (areset_n)
    );

    stream_route_top dut_i (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .rx_tvalid  (rx_tvalid),
        .rx_tready  (rx_tready),
        .rx_tdata   (rx_tdata),
        .rx_tdest   (rx_tdest),
        .rx_tlast   (rx_tlast),
        .tx_tvalid  (tx_tvalid),
        .tx_tready  (tx_tready),
        .tx_tdata   (tx_tdata),
        .tx_tdest   (tx_tdest),
        .tx_tlast   (tx_tlast),
        .drop_count (drop_count)
    );

    task automatic abort_run(input string text);
        $display("ERROR at %0t: %s", $time, text);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] want,
                                   input logic [63:0] got);
        abort_run($sformatf("%s expected %0h actual %0h", name, want, got));
    endtask

    task automatic put_entry(input int idx, input int dest, input logic [31:0] data,
                             input logic last, input logic rnd);
        stim[idx].dest     = stream_route_pkg::dest_t'(dest);
        stim[idx].data     = data;
        stim[idx].last     = last;
        stim[idx].rand_rdy = rnd;
    endtask

    task automatic build_table();
        // Every code once with all outputs ready
        put_entry(0,   0, 32'h0000_a000, 1'b1, 1'b0);
        put_entry(1,   1, 32'h1111_a001, 1'b0, 1'b0);
        put_entry(2,   2, 32'h2222_a002, 1'b1, 1'b0);
        put_entry(3,   3, 32'h3333_a003, 1'b0, 1'b0);
        put_entry(4,   8, 32'h8888_d008, 1'b1, 1'b0);   // Dropped
        put_entry(5,   4, 32'h4444_a004, 1'b1, 1'b0);
        put_entry(6,   5, 32'h5555_a005, 1'b0, 1'b0);
        put_entry(7,   9, 32'h9999_d009, 1'b0, 1'b0);   // Dropped
        put_entry(8,   6, 32'h6666_a006, 1'b1, 1'b0);
        put_entry(9,   7, 32'h7777_a007, 1'b1, 1'b0);
        put_entry(10, 10, 32'haaaa_d00a, 1'b1, 1'b0);
        put_entry(11, 11, 32'hbbbb_d00b, 1'b0, 1'b0);
        put_entry(12, 12, 32'hcccc_d00c, 1'b1, 1'b0);
        put_entry(13, 13, 32'hdddd_d00d, 1'b0, 1'b0);
        put_entry(14, 14, 32'heeee_d00e, 1'b1, 1'b0);
        put_entry(15, 15, 32'hffff_d00f, 1'b1, 1'b0);
        // Random codes under random back-pressure
        for (int i = 16; i < num_beats; i++) begin
            put_entry(i, $urandom_range(0, 15), $urandom, 1'($urandom_range(0, 1)), 1'b1);
        end
    endtask

    // Drives tx_tready all high or with random bits per edge
    task automatic drive_ready();
        logic [31:0] rnd_word;
        logic        mode;
        forever begin
            @(posedge aclk);
            mode = rand_ready;                          // Mode set during the last cycle
            #(drive_delay);
            rnd_word = $urandom;
            if (mode) begin
                tx_tready = rnd_word[outputs-1:0];
            end else begin
                tx_tready = '1;
            end
        end
    endtask

    task automatic check_idle_outputs();
        assert (rx_tready === 1'b0) else report_mismatch("rx_tready", 0, rx_tready);
        assert (tx_tvalid === '0) else report_mismatch("tx_tvalid", 0, tx_tvalid);
        assert (drop_count === '0) else report_mismatch("drop_count", 0, drop_count);
    endtask

    // Holds the beat from drive time until the rx handshake
    task automatic send_beat(input entry_t b);
        rx_tvalid = 1'b1;
        rx_tdata  = b.data;
        rx_tdest  = b.dest;
        rx_tlast  = b.last;
        @(posedge aclk);
        while (!rx_tready) @(posedge aclk);
        last_hs = cycle;
        if (int'(b.dest) < outputs) begin
            exp_q[b.dest].push_back(b);
        end else begin
            exp_drops++;
        end
        #(drive_delay);
    endtask

    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin                         // Longer than ingress plus both stages
            @(negedge aclk);                            // Settled between edges
            if ((tx_tvalid != '0) || lat_armed) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        repeat (3) @(posedge aclk);
    endtask

    always @(posedge aclk) begin
        cycle <= cycle + 1;
    end

    // Every tx handshake must match the head of its queue
    always @(posedge aclk) begin
        entry_t want;
        if (areset_n) begin
            for (int k = 0; k < outputs; k++) begin
                if (tx_tvalid[k] && tx_tready[k]) begin
                    assert (exp_q[k].size() > 0)
                    else abort_run($sformatf("output %0d delivered a beat never sent to it", k));
                    want = exp_q[k].pop_front();
                    assert (tx_tdata[k] === want.data)
                    else report_mismatch($sformatf("tx_tdata[%0d]", k), want.data, tx_tdata[k]);
                    assert (tx_tdest[k] === want.dest)
                    else report_mismatch($sformatf("tx_tdest[%0d]", k), want.dest, tx_tdest[k]);
                    assert (tx_tlast[k] === want.last)
                    else report_mismatch($sformatf("tx_tlast[%0d]", k), want.last, tx_tlast[k]);
                end
            end
            // First valid edge after a lone beat on an idle chain
            if (lat_armed && tx_tvalid[lat_out]) begin
                assert (cycle - lat_hs == 2 + lat_out / stream_route_pkg::group_size)
                else report_mismatch($sformatf("tx_tvalid[%0d] latency", lat_out),
                                     2 + lat_out / stream_route_pkg::group_size, cycle - lat_hs);
                lat_armed = 1'b0;
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge aclk);
        abort_run($sformatf("timeout, run did not finish within %0d cycles", timeout_cycles));
    end

    initial begin
        void'($urandom(96008));
        rx_tvalid  = 1'b0;
        rx_tdata   = '0;
        rx_tdest   = '0;
        rx_tlast   = 1'b0;
        tx_tready  = '1;
        rand_ready = 1'b0;
        exp_drops  = 0;
        cycle      = 0;
        last_hs    = 0;
        lat_out    = 0;
        lat_hs     = 0;
        lat_armed  = 1'b0;
        build_table();
        fork
            drive_ready();
        join_none

        repeat (2) @(posedge aclk);                     // Still inside reset
        check_idle_outputs();
        @(posedge areset_n);
        #1;
        check_idle_outputs();

        repeat (2) @(posedge aclk);
        #(drive_delay);
        for (int i = 0; i < num_beats; i++) begin
            rand_ready = stim[i].rand_rdy;
            send_beat(stim[i]);
        end
        rx_tvalid  = 1'b0;
        rand_ready = 1'b0;

        // One beat per output into an empty chain
        for (int k = 0; k < outputs; k++) begin
            wait_idle();
            #(drive_delay);
            lat_out = k;
            send_beat('{dest: stream_route_pkg::dest_t'(k), data: 32'h5a00_0000 + k,
                        last: 1'b1, rand_rdy: 1'b0});
            rx_tvalid = 1'b0;
            lat_hs    = last_hs;
            lat_armed = 1'b1;
        end
        wait_idle();
        repeat (4) @(posedge aclk);                     // Let any drop reach the tail
        @(negedge aclk);

        assert (int'(drop_count) == exp_drops)
        else report_mismatch("drop_count", exp_drops, drop_count);
        for (int k = 0; k < outputs; k++) begin
            assert (exp_q[k].size() == 0)
            else abort_run($sformatf("output %0d still owes %0d beats", k, exp_q[k].size()));
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
